// ==== source/nn_pkg.sv ====
package nn_pkg;

    // ========================================
    // widths
    // ========================================

    // pixels or weights per beat, the packed types below depend on it
    localparam int LANES = 4;

    // unsigned pixel
    localparam int PIXEL_W = 8;

    // signed weight
    localparam int WEIGHT_W = 8;

    // signed accumulator, wide enough for a full image of products
    localparam int ACC_W = 22;

    // unsigned clipped score
    localparam int SCORE_W = 8;

    // ========================================
    // data words
    // ========================================

    // lane 0 in the low bits
    typedef logic [LANES-1:0][PIXEL_W-1:0] pixel_vec_t;

    // same lane order as pixel_vec_t, each lane read as signed
    typedef logic [LANES-1:0][WEIGHT_W-1:0] weight_vec_t;

    // one chunk of operands for the dot-product unit
    // first / last bound one class's dot product
    typedef struct packed {
        logic        valid;
        logic        first;
        logic        last;
        pixel_vec_t  pixels;
        weight_vec_t weights;
        logic [7:0]  score_addr;
    } operand_beat_t;

    // ========================================
    // write ports
    // ========================================

    // score memory write, from the dot-product unit
    typedef struct packed {
        logic               en;
        logic [7:0]         addr;
        logic [SCORE_W-1:0] score;
    } score_wr_t;

    // host write into the image memory
    typedef struct packed {
        logic       en;
        logic [7:0] addr;
        pixel_vec_t pixels;
    } image_wr_t;

    // host write into the weight memory
    typedef struct packed {
        logic        en;
        logic [7:0]  addr;
        weight_vec_t weights;
    } weight_wr_t;

endpackage

// ==== source/dual_port_ram.sv ====
`timescale 1ns/1ps

// simple dual-port memory, one write port and one read port on one clock
// word type set per instance (pixel, weight or score words)
module dual_port_ram #(
    parameter type word_t = logic [7:0],
    parameter int  depth  = 16
) (
    input  logic                                     clk,
    // write port
    input  logic                                     wr_en,
    input  logic [$clog2(depth > 1 ? depth : 2)-1:0] wr_addr,
    input  word_t                                    wr_data,
    // read port, data one cycle after rd_en
    input  logic                                     rd_en,
    input  logic [$clog2(depth > 1 ? depth : 2)-1:0] rd_addr,
    output word_t                                    rd_data
);

    // ========================================
    // storage
    // ========================================

    word_t mem [depth];

    // write lands at the clock edge, readable from the next cycle
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, old data kept while rd_en is low
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

    // ========================================
    // checks
    // ========================================

    // non power-of-two depths leave holes in the address space
    wr_addr_in_range : assert property (
        @(posedge clk) wr_en |-> (wr_addr < depth)
    );

    rd_addr_in_range : assert property (
        @(posedge clk) rd_en |-> (rd_addr < depth)
    );

endmodule

// ==== source/batch_sequencer.sv ====
`timescale 1ns/1ps

// steps through the batch, one image after another
// an image ends when its last class score is written
module batch_sequencer #(
    parameter int num_images  = 4,
    parameter int num_classes = 4
) (
    input  logic              clk,
    input  logic              resetn,
    input  logic              start,
    input  nn_pkg::score_wr_t score_wr,
    output logic              image_start,
    output logic [7:0]        image_idx,
    output logic              done
);

    localparam int idx_w = $clog2(num_images > 1 ? num_images : 2);

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_finished
    } state_t;

    state_t           state_q;
    logic [idx_w-1:0] idx_q;
    logic [7:0]       last_addr;
    logic             image_end;
    logic             last_image;

    // ========================================
    // end of image detection
    // ========================================

    // score address of the last class of the current image
    assign last_addr = 8'(idx_q * num_classes + num_classes - 1);

    assign image_end  = score_wr.en && (score_wr.addr == last_addr);
    assign last_image = idx_q == idx_w'(num_images - 1);

    // zero extended for the fetcher's address math
    assign image_idx = 8'(idx_q);

    // ========================================
    // state machine
    // ========================================

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state_q     <= st_idle;
            idx_q       <= '0;
            image_start <= 1'b0;
            done        <= 1'b0;
        end else begin
            // one-cycle pulse unless set below
            image_start <= 1'b0;
            case (state_q)
                // idle and finished both accept a new batch
                st_idle, st_finished: begin
                    if (start) begin
                        state_q     <= st_run;
                        idx_q       <= '0;
                        image_start <= 1'b1;
                        done        <= 1'b0;
                    end
                end
                // start is ignored here
                st_run: begin
                    if (image_end) begin
                        if (last_image) begin
                            state_q <= st_finished;
                            done    <= 1'b1;
                        end else begin
                            // next image starts right after the score write
                            idx_q       <= idx_q + 1'b1;
                            image_start <= 1'b1;
                        end
                    end
                end
                default: begin
                    state_q <= st_idle;
                end
            endcase
        end
    end

    // ========================================
    // checks
    // ========================================

    // the datapath only writes scores for images this block started
    no_score_outside_run : assert property (
        @(posedge clk) disable iff (!resetn)
        (state_q != st_run) |-> !score_wr.en
    );

endmodule

// ==== source/feature_fetch.sv ====
`timescale 1ns/1ps

// walks classes and chunks of one image
// one image read and one weight read per cycle, data paired into beats
module feature_fetch #(
    parameter int num_classes      = 4,
    parameter int chunks_per_image = 4
) (
    input  logic                  clk,
    input  logic                  resetn,
    input  logic                  image_start,
    input  logic [7:0]            image_idx,
    // image memory read port
    output logic                  img_rd_en,
    output logic [7:0]            img_rd_addr,
    input  nn_pkg::pixel_vec_t    img_rd_data,
    // weight memory read port
    output logic                  wgt_rd_en,
    output logic [7:0]            wgt_rd_addr,
    input  nn_pkg::weight_vec_t   wgt_rd_data,
    // operands to the dot-product unit
    output nn_pkg::operand_beat_t beat
);

    localparam int cls_w = $clog2(num_classes > 1 ? num_classes : 2);
    localparam int chk_w = $clog2(chunks_per_image > 1 ? chunks_per_image : 2);

    logic             busy_q;
    logic [cls_w-1:0] cls_q;
    logic [chk_w-1:0] chk_q;
    logic             chk_end;
    logic             cls_end;
    logic             rd_valid_q;
    logic             first_q;
    logic             last_q;
    logic [7:0]       score_addr_q;

    // ========================================
    // class / chunk counters
    // ========================================

    assign chk_end = chk_q == chk_w'(chunks_per_image - 1);
    assign cls_end = cls_q == cls_w'(num_classes - 1);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy_q <= 1'b0;
            cls_q  <= '0;
            chk_q  <= '0;
        end else if (image_start) begin
            busy_q <= 1'b1;
            cls_q  <= '0;
            chk_q  <= '0;
        end else if (busy_q) begin
            if (chk_end) begin
                chk_q <= '0;
                // last chunk of last class ends the image
                if (cls_end) begin
                    busy_q <= 1'b0;
                end else begin
                    cls_q <= cls_q + 1'b1;
                end
            end else begin
                chk_q <= chk_q + 1'b1;
            end
        end
    end

    // ========================================
    // read addresses
    // ========================================

    // both memories read in lockstep while busy
    assign img_rd_en = busy_q;
    assign wgt_rd_en = busy_q;

    // image rows are per image, weight rows are per class
    assign img_rd_addr = 8'(image_idx * chunks_per_image + chk_q);
    assign wgt_rd_addr = 8'(cls_q * chunks_per_image + chk_q);

    // ========================================
    // beat alignment
    // ========================================

    // valid tracks the one-cycle memory latency
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            rd_valid_q <= 1'b0;
        end else begin
            rd_valid_q <= busy_q;
        end
    end

    // markers only matter when rd_valid_q is set
    always_ff @(posedge clk) begin
        first_q      <= chk_q == '0;
        last_q       <= chk_end;
        score_addr_q <= 8'(image_idx * num_classes + cls_q);
    end

    always_comb begin
        beat.valid      = rd_valid_q;
        beat.first      = first_q;
        beat.last       = last_q;
        beat.pixels     = img_rd_data;
        beat.weights    = wgt_rd_data;
        beat.score_addr = score_addr_q;
    end

    // ========================================
    // checks
    // ========================================

    // sequencer waits for the score write, so a new image never overlaps
    no_start_while_busy : assert property (
        @(posedge clk) disable iff (!resetn)
        image_start |-> !busy_q
    );

endmodule

// ==== source/dot_product_pe.sv ====
`timescale 1ns/1ps

// lane-parallel multiply-accumulate over the chunks of one class
// clipped score written one cycle after the last chunk
module dot_product_pe (
    input  logic                  clk,
    input  logic                  resetn,
    input  nn_pkg::operand_beat_t beat,
    output nn_pkg::score_wr_t     score_wr
);

    localparam int score_max = (1 << nn_pkg::SCORE_W) - 1;

    logic signed [nn_pkg::ACC_W-1:0] lane_sum;
    logic signed [nn_pkg::ACC_W-1:0] total;
    logic signed [nn_pkg::ACC_W-1:0] acc_q;
    logic [nn_pkg::SCORE_W-1:0]      clipped;
    logic                            open_q;
    logic                            wr_en_q;
    logic [7:0]                      wr_addr_q;
    logic [nn_pkg::SCORE_W-1:0]      wr_score_q;

    // ========================================
    // multiply and add
    // ========================================

    // pixel zero extended to keep it unsigned, weight signed
    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < nn_pkg::LANES; i++) begin
            lane_sum = lane_sum + ($signed({1'b0, beat.pixels[i]}) * $signed(beat.weights[i]));
        end
    end

    // first chunk restarts the sum
    assign total = beat.first ? lane_sum : acc_q + lane_sum;

    always_ff @(posedge clk) begin
        if (beat.valid) begin
            acc_q <= total;
        end
    end

    // ========================================
    // clip and write
    // ========================================

    always_comb begin
        if (total < 0) begin
            clipped = '0;
        end else if (total > score_max) begin
            clipped = '1;
        end else begin
            clipped = total[nn_pkg::SCORE_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= beat.valid && beat.last;
        end
    end

    always_ff @(posedge clk) begin
        if (beat.valid && beat.last) begin
            wr_addr_q  <= beat.score_addr;
            wr_score_q <= clipped;
        end
    end

    assign score_wr.en    = wr_en_q;
    assign score_wr.addr  = wr_addr_q;
    assign score_wr.score = wr_score_q;

    // ========================================
    // checks
    // ========================================

    // set between a first and its matching last
    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            open_q <= 1'b0;
        end else if (beat.valid) begin
            if (beat.last) begin
                open_q <= 1'b0;
            end else if (beat.first) begin
                open_q <= 1'b1;
            end
        end
    end

    // fetcher must close each class before opening the next
    first_after_last : assert property (
        @(posedge clk) disable iff (!resetn)
        (beat.valid && beat.first) |-> !open_q
    );

endmodule

// ==== source/batch_classifier_top.sv ====
`timescale 1ns/1ps

// batch classifier, one fully-connected layer per image
// host loads pixels and weights, pulses start, waits for done, reads scores
module batch_classifier_top #(
    parameter int num_images       = 4,
    parameter int num_classes      = 4,
    parameter int chunks_per_image = 4
) (
    input  logic                       clk,
    input  logic                       resetn,
    input  logic                       start,
    output logic                       done,
    // host write ports, absolute addresses
    input  nn_pkg::image_wr_t          img_wr,
    input  nn_pkg::weight_wr_t         wgt_wr,
    // host score read, data one cycle later
    input  logic                       score_rd_en,
    input  logic [7:0]                 score_rd_addr,
    output logic [nn_pkg::SCORE_W-1:0] score_rd_data
);

    localparam int img_depth   = num_images * chunks_per_image;
    localparam int wgt_depth   = num_classes * chunks_per_image;
    localparam int score_depth = num_images * num_classes;
    localparam int img_aw      = $clog2(img_depth > 1 ? img_depth : 2);
    localparam int wgt_aw      = $clog2(wgt_depth > 1 ? wgt_depth : 2);
    localparam int score_aw    = $clog2(score_depth > 1 ? score_depth : 2);

    // ========================================
    // internal wires
    // ========================================

    // sequencer to fetcher
    logic                  image_start;
    logic [7:0]            image_idx;

    // fetcher to memories
    logic                  img_rd_en;
    logic [7:0]            img_rd_addr;
    nn_pkg::pixel_vec_t    img_rd_data;
    logic                  wgt_rd_en;
    logic [7:0]            wgt_rd_addr;
    nn_pkg::weight_vec_t   wgt_rd_data;

    // fetcher to dot-product unit
    nn_pkg::operand_beat_t beat;

    // dot-product unit to score memory and sequencer
    nn_pkg::score_wr_t     score_wr;

    // ========================================
    // control
    // ========================================

    batch_sequencer #(
        .num_images  (num_images),
        .num_classes (num_classes)
    ) batch_sequencer_i (
        .clk         (clk),
        .resetn      (resetn),
        .start       (start),
        .score_wr    (score_wr),
        .image_start (image_start),
        .image_idx   (image_idx),
        .done        (done)
    );

    // ========================================
    // memories
    // ========================================

    // pixel chunks, image i chunk c at i * chunks_per_image + c
    dual_port_ram #(
        .word_t (nn_pkg::pixel_vec_t),
        .depth  (img_depth)
    ) image_ram_i (
        .clk     (clk),
        .wr_en   (img_wr.en),
        .wr_addr (img_wr.addr[img_aw-1:0]),
        .wr_data (img_wr.pixels),
        .rd_en   (img_rd_en),
        .rd_addr (img_rd_addr[img_aw-1:0]),
        .rd_data (img_rd_data)
    );

    // weight chunks, shared by every image
    dual_port_ram #(
        .word_t (nn_pkg::weight_vec_t),
        .depth  (wgt_depth)
    ) weight_ram_i (
        .clk     (clk),
        .wr_en   (wgt_wr.en),
        .wr_addr (wgt_wr.addr[wgt_aw-1:0]),
        .wr_data (wgt_wr.weights),
        .rd_en   (wgt_rd_en),
        .rd_addr (wgt_rd_addr[wgt_aw-1:0]),
        .rd_data (wgt_rd_data)
    );

    // scores, image i class k at i * num_classes + k
    dual_port_ram #(
        .word_t (logic [nn_pkg::SCORE_W-1:0]),
        .depth  (score_depth)
    ) score_ram_i (
        .clk     (clk),
        .wr_en   (score_wr.en),
        .wr_addr (score_wr.addr[score_aw-1:0]),
        .wr_data (score_wr.score),
        .rd_en   (score_rd_en),
        .rd_addr (score_rd_addr[score_aw-1:0]),
        .rd_data (score_rd_data)
    );

    // ========================================
    // datapath
    // ========================================

    feature_fetch #(
        .num_classes      (num_classes),
        .chunks_per_image (chunks_per_image)
    ) feature_fetch_i (
        .clk         (clk),
        .resetn      (resetn),
        .image_start (image_start),
        .image_idx   (image_idx),
        .img_rd_en   (img_rd_en),
        .img_rd_addr (img_rd_addr),
        .img_rd_data (img_rd_data),
        .wgt_rd_en   (wgt_rd_en),
        .wgt_rd_addr (wgt_rd_addr),
        .wgt_rd_data (wgt_rd_data),
        .beat        (beat)
    );

    dot_product_pe dot_product_pe_i (
        .clk      (clk),
        .resetn   (resetn),
        .beat     (beat),
        .score_wr (score_wr)
    );

endmodule

// ==== test/tb_batch_classifier.sv ====
`timescale 1ns/1ps

// testbench for the batch classifier
// loads pixels and weights, runs batches and checks every score against a model
module tb_batch_classifier;

    localparam int num_images       = 4;
    localparam int num_classes      = 4;
    localparam int chunks_per_image = 4;
    localparam int img_words        = num_images * chunks_per_image;
    localparam int wgt_words        = num_classes * chunks_per_image;
    localparam int pixels_per_image = chunks_per_image * nn_pkg::LANES;
    // per image: image_start, one read per chunk of every class, beat, score write
    localparam int batch_cycles     = num_images * (num_classes * chunks_per_image + 3);
    // a batch needs well under a hundred cycles
    localparam int done_timeout     = 1000;

    logic                       clk;
    logic                       resetn;
    logic                       start;
    logic                       done;
    nn_pkg::image_wr_t          img_wr;
    nn_pkg::weight_wr_t         wgt_wr;
    logic                       score_rd_en;
    logic [7:0]                 score_rd_addr;
    logic [nn_pkg::SCORE_W-1:0] score_rd_data;

    // what the host loaded, kept for the model
    nn_pkg::pixel_vec_t  pix_copy [img_words];
    nn_pkg::weight_vec_t wgt_copy [wgt_words];

    int test_errors;
    int total_errors;
    int tests_run;
    int tests_failed;
    int cycle_count;

    // 10 ns clock
    initial clk = 1'b0;
    always #5 clk = ~clk;

    // free-running, read on the falling edge
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    batch_classifier_top #(
        .num_images       (num_images),
        .num_classes      (num_classes),
        .chunks_per_image (chunks_per_image)
    ) batch_classifier_top_i (
        .clk           (clk),
        .resetn        (resetn),
        .start         (start),
        .done          (done),
        .img_wr        (img_wr),
        .wgt_wr        (wgt_wr),
        .score_rd_en   (score_rd_en),
        .score_rd_addr (score_rd_addr),
        .score_rd_data (score_rd_data)
    );

    // ========================================
    // reference model
    // ========================================

    // signed sum of pixel times weight over the image, clipped to 0..255
    function automatic int expected_score(input int img, input int cls);
        int sum;
        int p;
        int w;
        sum = 0;
        for (int c = 0; c < chunks_per_image; c++) begin
            for (int l = 0; l < nn_pkg::LANES; l++) begin
                // pixel unsigned, weight signed
                p = int'(pix_copy[img * chunks_per_image + c][l]);
                w = int'($signed(wgt_copy[cls * chunks_per_image + c][l]));
                sum = sum + p * w;
            end
        end
        if (sum < 0) begin
            return 0;
        end
        if (sum > 255) begin
            return 255;
        end
        return sum;
    endfunction

    // ========================================
    // host helpers
    // ========================================

    // copy both testbench arrays into the DUT memories, one word per port per cycle
    task automatic load_memories();
        for (int a = 0; a < img_words || a < wgt_words; a++) begin
            @(posedge clk);
            img_wr.en <= a < img_words;
            wgt_wr.en <= a < wgt_words;
            if (a < img_words) begin
                img_wr.addr   <= 8'(a);
                img_wr.pixels <= pix_copy[a];
            end
            if (a < wgt_words) begin
                wgt_wr.addr    <= 8'(a);
                wgt_wr.weights <= wgt_copy[a];
            end
        end
        @(posedge clk);
        img_wr.en <= 1'b0;
        wgt_wr.en <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
    endtask

    // done sampled on the falling edge, away from the updates
    task automatic wait_done(input string name);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!done && cycles < done_timeout) begin
            @(negedge clk);
            cycles++;
        end
        assert (done) else begin
            $display("%s: done did not rise within %0d cycles", name, done_timeout);
            test_errors++;
        end
    endtask

    // data is back one cycle after the enabled read
    task automatic read_score(input int addr, output int value);
        @(posedge clk);
        score_rd_en   <= 1'b1;
        score_rd_addr <= 8'(addr);
        @(posedge clk);
        score_rd_en <= 1'b0;
        @(negedge clk);
        value = int'(score_rd_data);
    endtask

    task automatic check_value(input string name, input int addr, input int exp, input int got);
        assert (got == exp) else begin
            $display("ERR %s addr %0d expected %0d actual %0d", name, addr, exp, got);
            test_errors++;
        end
    endtask

    // start a batch, done must clear and then rise after the full batch length
    // an optional second start while busy must not stretch the batch
    task automatic run_batch(input string name, input bit stray_start);
        int t0;
        pulse_start();
        @(negedge clk);
        t0 = cycle_count;
        assert (!done) else begin
            $display("%s: done still high after start", name);
            test_errors++;
        end
        if (stray_start) begin
            // busy now, this start must be ignored
            repeat (5) @(posedge clk);
            pulse_start();
        end
        wait_done(name);
        assert (cycle_count - t0 == batch_cycles) else begin
            $display("ERR %s batch length expected %0d actual %0d",
                     name, batch_cycles, cycle_count - t0);
            test_errors++;
        end
    endtask

    // every score of the batch against the model
    task automatic check_all_scores(input string name);
        int got;
        for (int i = 0; i < num_images; i++) begin
            for (int k = 0; k < num_classes; k++) begin
                read_score(i * num_classes + k, got);
                check_value(name, i * num_classes + k, expected_score(i, k), got);
            end
        end
    endtask

    task automatic report_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
            tests_failed++;
        end
        total_errors = total_errors + test_errors;
        test_errors  = 0;
    endtask

    // ========================================
    // tests
    // ========================================

    // no start, so done must stay low
    task automatic test_after_reset();
        for (int i = 0; i < 20; i++) begin
            @(negedge clk);
            assert (!done) else begin
                $display("after_reset: done rose without start at cycle %0d", i);
                test_errors++;
            end
        end
        report_test("after_reset");
    endtask

    // all pixels 1, class k weights k, so score = pixels per image * k
    task automatic test_known_batch();
        int got;
        for (int a = 0; a < img_words; a++) begin
            pix_copy[a] = {nn_pkg::LANES{8'd1}};
        end
        for (int k = 0; k < num_classes; k++) begin
            for (int c = 0; c < chunks_per_image; c++) begin
                wgt_copy[k * chunks_per_image + c] = {nn_pkg::LANES{8'(k)}};
            end
        end
        load_memories();
        run_batch("known_batch", 1'b0);
        for (int i = 0; i < num_images; i++) begin
            for (int k = 0; k < num_classes; k++) begin
                read_score(i * num_classes + k, got);
                check_value("known_batch", i * num_classes + k, pixels_per_image * k, got);
            end
        end
        report_test("known_batch");
    endtask

    // class 0 saturates high, class 1 low, classes 2 and 3 from the model
    task automatic test_clipping();
        int got;
        int exp;
        for (int a = 0; a < img_words; a++) begin
            for (int l = 0; l < nn_pkg::LANES; l++) begin
                pix_copy[a][l] = 8'($urandom_range(255, 16));
            end
        end
        for (int c = 0; c < chunks_per_image; c++) begin
            for (int l = 0; l < nn_pkg::LANES; l++) begin
                wgt_copy[c][l]                        = 8'(100);
                wgt_copy[chunks_per_image + c][l]     = 8'(-100);
                // alternating signs land anywhere
                wgt_copy[2 * chunks_per_image + c][l] = (l % 2 == 0) ? 8'(3) : 8'(-3);
                wgt_copy[3 * chunks_per_image + c][l] = 8'(0);
            end
        end
        load_memories();
        run_batch("clipping", 1'b0);
        for (int i = 0; i < num_images; i++) begin
            for (int k = 0; k < num_classes; k++) begin
                if (k == 0) begin
                    exp = 255;
                end else if (k == 1) begin
                    exp = 0;
                end else begin
                    exp = expected_score(i, k);
                end
                read_score(i * num_classes + k, got);
                check_value("clipping", i * num_classes + k, exp, got);
            end
        end
        report_test("clipping");
    endtask

    // pixels 0..15, weights -8..7
    task automatic test_random_batch();
        for (int a = 0; a < img_words; a++) begin
            for (int l = 0; l < nn_pkg::LANES; l++) begin
                pix_copy[a][l] = 8'($urandom_range(15));
            end
        end
        for (int a = 0; a < wgt_words; a++) begin
            for (int l = 0; l < nn_pkg::LANES; l++) begin
                wgt_copy[a][l] = 8'(int'($urandom_range(15)) - 8);
            end
        end
        load_memories();
        run_batch("random_batch", 1'b0);
        check_all_scores("random_batch");
        report_test("random_batch");
    endtask

    // new weights after done, plus a stray start in the middle of the batch
    task automatic test_restart();
        assert (done) else begin
            $display("restart: done not high before the second batch");
            test_errors++;
        end
        for (int a = 0; a < wgt_words; a++) begin
            for (int l = 0; l < nn_pkg::LANES; l++) begin
                wgt_copy[a][l] = 8'(int'($urandom_range(8)) - 4);
            end
        end
        load_memories();
        run_batch("restart", 1'b1);
        check_all_scores("restart");
        report_test("restart");
    endtask

    // ========================================
    // main sequence
    // ========================================

    initial begin
        void'($urandom(32'h7ce5));
        resetn        = 1'b0;
        start         = 1'b0;
        img_wr        = '0;
        wgt_wr        = '0;
        score_rd_en   = 1'b0;
        score_rd_addr = '0;
        test_errors   = 0;
        total_errors  = 0;
        tests_run     = 0;
        tests_failed  = 0;
        cycle_count   = 0;

        // reset held for two cycles
        repeat (2) @(posedge clk);
        resetn <= 1'b1;

        test_after_reset();
        test_known_batch();
        test_clipping();
        test_random_batch();
        test_restart();

        $display("tests run %0d, tests failed %0d, failed checks %0d",
                 tests_run, tests_failed, total_errors);
        if (tests_failed == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// ==== flist.f ====
source/nn_pkg.sv
source/dual_port_ram.sv
source/batch_sequencer.sv
source/feature_fetch.sv
source/dot_product_pe.sv
source/batch_classifier_top.sv
test/tb_batch_classifier.sv

// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the regression"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module tb_batch_classifier -Mdir obj_dir -o sim_tb
	@out="$$(./obj_dir/sim_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Regression passed$$"

clean:
	rm -rf obj_dir
